/* all.f */
+incdir+include
source/codec_pkg.sv
source/codec_config_rom.sv
source/codec_reg_shadow.sv
source/codec_cfg_sequencer.sv
source/i2c_write_master.sv
source/codec_config_top.sv
tb/tb_i2c_codec_model.sv
tb/tb_codec_config.sv

/* include/codec_params.svh */
`ifndef CODEC_PARAMS_SVH
`define CODEC_PARAMS_SVH

// WM8731 write address on the I2C bus, CSB tied low
`define CODEC_DEV_ADDR 8'h34

// registers 0 to 9 are written at power-up
`define CODEC_NUM_REGS 10

// system cycles per quarter of an SCL period
`define I2C_CLK_DIV 8

// host bus widths
`define WB_ADDR_W 5
`define WB_DATA_W 16

`endif

/* run.sh */
#!/bin/sh
# build with Verilator, run the testbench, then judge the run by its log
rm -f sim.log
verilator --binary --timing --top-module tb_codec_config -Mdir obj_dir -f all.f \
  && { ./obj_dir/Vtb_codec_config > sim.log 2>&1; cat sim.log; } \
  && ! grep -q "Simulation failed" sim.log \
  && grep -q "Simulation passed" sim.log \
  || { echo "FAIL"; exit 1; }
echo "PASS"

/* source/codec_cfg_sequencer.sv */
`include "codec_params.svh"

module codec_cfg_sequencer (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      start,
  input  codec_pkg::override_bank_t overrides,
  output logic [3:0]                rom_addr,
  input  codec_pkg::cfg_word_t      rom_word,
  output codec_pkg::cfg_word_t      tx_word,
  output logic                      tx_start,
  input  logic                      tx_done,
  input  logic                      tx_nack,
  output codec_pkg::cfg_status_t    status
);
  import codec_pkg::*;

  localparam logic [3:0] LAST_IDX = 4'(`CODEC_NUM_REGS - 1);

  seq_state_e state;
  logic [3:0] index;
  override_t  ovr;
  cfg_word_t  merged;

  assign rom_addr = index;
  assign tx_start = (state == SEQ_SEND);
  assign ovr      = overrides[index];

  // host data wins over the default when its valid bit is set
  always_comb begin
    merged = rom_word;
    if (ovr.valid) begin
      merged.reg_data = ovr.data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= SEQ_IDLE;
      index  <= '0;
      status <= '0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            index       <= '0;
            status.busy <= 1'b1;
            status.done <= 1'b0;   // new run clears the last result
            status.nack <= 1'b0;
            state       <= SEQ_LOAD;
          end
        end
        SEQ_LOAD: state <= SEQ_SEND;
        SEQ_SEND: state <= SEQ_WAIT;
        SEQ_WAIT: begin
          if (tx_done) begin
            if (tx_nack) begin
              status.nack <= 1'b1;   // skip what is left
              state       <= SEQ_FINISH;
            end else if (index == LAST_IDX) begin
              state <= SEQ_FINISH;
            end else begin
              index <= index + 1'b1;
              state <= SEQ_LOAD;
            end
          end
        end
        SEQ_FINISH: begin
          status.busy <= 1'b0;
          status.done <= 1'b1;
          state       <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // word held stable for the whole transfer
  always_ff @(posedge clk) begin
    if (state == SEQ_LOAD) begin
      tx_word <= merged;
    end
  end

  rom_addr_in_range: assert property (
    @(posedge clk) disable iff (!arst_n) status.busy |-> (rom_addr <= LAST_IDX)
  ) else $error("rom_addr out of range during a run");

endmodule

/* source/codec_config_rom.sv */
`include "codec_params.svh"

module codec_config_rom (
  input  logic [3:0]           addr,
  output codec_pkg::cfg_word_t config_data
);

  // reg 0/1, line in
  localparam logic       LRIN_BOTH = 1'b0;
  localparam logic       RLIN_BOTH = 1'b0;
  localparam logic       LIN_MUTE  = 1'b0;
  localparam logic       RIN_MUTE  = 1'b0;
  localparam logic [4:0] LINVOL    = 5'b11010;
  localparam logic [4:0] RINVOL    = 5'b11010;

  // reg 2/3, headphone out
  localparam logic       LRHP_BOTH = 1'b0;
  localparam logic       RLHP_BOTH = 1'b0;
  localparam logic       LZCEN     = 1'b0;
  localparam logic       RZCEN     = 1'b0;
  localparam logic [6:0] LHPVOL    = 7'b1110010;
  localparam logic [6:0] RHPVOL    = 7'b1110010;

  // reg 4, analog path
  localparam logic [1:0] SIDEATT   = 2'b01;
  localparam logic       SIDETONE  = 1'b1;
  localparam logic       DAC_SEL   = 1'b1;   // DAC to output mixer
  localparam logic       BYPASS    = 1'b1;
  localparam logic       INSEL     = 1'b1;
  localparam logic       MUTE_MIC  = 1'b0;
  localparam logic       MIC_BOOST = 1'b0;

  // reg 5, digital path
  localparam logic       HPOR      = 1'b0;
  localparam logic       DAC_MU    = 1'b0;
  localparam logic [1:0] DEEMPH    = 2'b11;
  localparam logic       ADC_HPD   = 1'b0;

  // reg 6, power down bits, all blocks on
  localparam logic [7:0] PWR_DOWN  = 8'h00;

  // reg 7, data format
  localparam logic       BCLK_INV  = 1'b0;
  localparam logic       MS        = 1'b0;   // codec is slave
  localparam logic       LR_SWAP   = 1'b0;
  localparam logic       LRP       = 1'b0;
  localparam logic [1:0] IWL       = 2'b00;  // 16 bit samples
  localparam logic [1:0] FORMAT    = 2'b01;  // left justified

  // reg 8, sampling
  localparam logic [3:0] SR        = 4'b0000; // 48 kHz
  localparam logic       CLKO_DIV2 = 1'b0;
  localparam logic       CLKI_DIV2 = 1'b0;
  localparam logic       BOSR      = 1'b1;
  localparam logic       USB_NORM  = 1'b0;

  // reg 9
  localparam logic       ACTIVE    = 1'b1;

  localparam logic [8:0] R0 = {LRIN_BOTH, LIN_MUTE, 2'b00, LINVOL};
  localparam logic [8:0] R1 = {RLIN_BOTH, RIN_MUTE, 2'b00, RINVOL};
  localparam logic [8:0] R2 = {LRHP_BOTH, LZCEN, LHPVOL};
  localparam logic [8:0] R3 = {RLHP_BOTH, RZCEN, RHPVOL};
  localparam logic [8:0] R4 = {1'b0, SIDEATT, SIDETONE, DAC_SEL, BYPASS, INSEL, MUTE_MIC,
                               MIC_BOOST};
  localparam logic [8:0] R5 = {4'b0000, HPOR, DAC_MU, DEEMPH, ADC_HPD};
  localparam logic [8:0] R6 = {1'b0, PWR_DOWN};
  localparam logic [8:0] R7 = {1'b0, BCLK_INV, MS, LR_SWAP, LRP, IWL, FORMAT};
  localparam logic [8:0] R8 = {1'b0, CLKO_DIV2, CLKI_DIV2, SR, BOSR, USB_NORM};
  localparam logic [8:0] R9 = {8'h00, ACTIVE};

  always_comb begin
    config_data.dev_addr = `CODEC_DEV_ADDR;
    config_data.reg_addr = {3'b000, addr};
    case (addr)
      4'h0: config_data.reg_data = R0;
      4'h1: config_data.reg_data = R1;
      4'h2: config_data.reg_data = R2;
      4'h3: config_data.reg_data = R3;
      4'h4: config_data.reg_data = R4;
      4'h5: config_data.reg_data = R5;
      4'h6: config_data.reg_data = R6;
      4'h7: config_data.reg_data = R7;
      4'h8: config_data.reg_data = R8;
      4'h9: config_data.reg_data = R9;
      default: config_data = '{dev_addr: 8'h00, reg_addr: 7'h09, reg_data: 9'h000}; // inactive
    endcase
  end

endmodule

/* source/codec_config_top.sv */
`include "codec_params.svh"

module codec_config_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  codec_pkg::wb_req_t    wb_req,
  output logic [`WB_DATA_W-1:0] wb_dat_o,
  output logic                  wb_ack,
  output logic                  scl,
  output logic                  sda_oe,
  input  logic                  sda_in
);
  import codec_pkg::*;

  logic           start;
  override_bank_t overrides;
  cfg_status_t    status;
  logic [3:0]     rom_addr;
  cfg_word_t      rom_word;
  cfg_word_t      tx_word;
  logic           tx_start;
  logic           tx_done;
  logic           tx_nack;

  codec_reg_shadow u_shadow (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_req    (wb_req),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .status    (status),
    .start     (start),
    .overrides (overrides)
  );

  codec_config_rom u_rom (
    .addr        (rom_addr),
    .config_data (rom_word)
  );

  codec_cfg_sequencer u_seq (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .overrides (overrides),
    .rom_addr  (rom_addr),
    .rom_word  (rom_word),
    .tx_word   (tx_word),
    .tx_start  (tx_start),
    .tx_done   (tx_done),
    .tx_nack   (tx_nack),
    .status    (status)
  );

  i2c_write_master u_i2c (
    .clk      (clk),
    .arst_n   (arst_n),
    .tx_word  (tx_word),
    .tx_start (tx_start),
    .tx_done  (tx_done),
    .tx_nack  (tx_nack),
    .scl      (scl),
    .sda_oe   (sda_oe),
    .sda_in   (sda_in)
  );

endmodule

/* source/codec_pkg.sv */
`include "codec_params.svh"

package codec_pkg;

  // one codec write as it goes out on the wire
  typedef struct packed {
    logic [7:0] dev_addr;
    logic [6:0] reg_addr;
    logic [8:0] reg_data;
  } cfg_word_t;

  typedef struct packed {
    logic       valid;   // replaces the ROM data when set
    logic [8:0] data;
  } override_t;

  typedef override_t [`CODEC_NUM_REGS-1:0] override_bank_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic nack;
  } cfg_status_t;

  // Wishbone classic request from the host
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`WB_ADDR_W-1:0] adr;
    logic [`WB_DATA_W-1:0] dat;
  } wb_req_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_LOAD,    // merge ROM and override word
    SEQ_SEND,    // one-cycle kick to the I2C master
    SEQ_WAIT,
    SEQ_FINISH
  } seq_state_e;

  typedef enum logic [2:0] {
    I2C_IDLE,
    I2C_START,
    I2C_BIT,
    I2C_ACK,
    I2C_STOP
  } i2c_state_e;

endpackage

/* source/codec_reg_shadow.sv */
`include "codec_params.svh"

module codec_reg_shadow (
  input  logic                      clk,
  input  logic                      arst_n,
  input  codec_pkg::wb_req_t        wb_req,
  output logic [`WB_DATA_W-1:0]     wb_dat_o,
  output logic                      wb_ack,
  input  codec_pkg::cfg_status_t    status,
  output logic                      start,
  output codec_pkg::override_bank_t overrides
);
  import codec_pkg::*;

  localparam logic [`WB_ADDR_W-1:0] ADDR_CTRL   = 'h00;
  localparam logic [`WB_ADDR_W-1:0] ADDR_STATUS = 'h01;
  localparam logic [`WB_ADDR_W-1:0] ADDR_OVR    = 'h10; // base of the override window
  localparam logic [3:0]            LAST_IDX    = 4'(`CODEC_NUM_REGS - 1);

  logic                  access;
  logic [3:0]            ovr_idx;
  logic                  ovr_hit;
  logic [`WB_DATA_W-1:0] rd_data;

  // ack in flight blocks a second access while stb is still held
  assign access  = wb_req.cyc && wb_req.stb && !wb_ack;
  assign ovr_idx = wb_req.adr[3:0];
  assign ovr_hit = (wb_req.adr[`WB_ADDR_W-1:4] == ADDR_OVR[`WB_ADDR_W-1:4]) &&
                   (ovr_idx <= LAST_IDX);

  always_comb begin
    rd_data = '0;   // CTRL and unmapped addresses read zero
    if (wb_req.adr == ADDR_STATUS) begin
      rd_data[2:0] = {status.nack, status.done, status.busy};
    end else if (ovr_hit) begin
      rd_data[9:0] = {overrides[ovr_idx].valid, overrides[ovr_idx].data};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack    <= 1'b0;
      start     <= 1'b0;
      overrides <= '0;
    end else begin
      wb_ack <= access;
      start  <= access && wb_req.we && (wb_req.adr == ADDR_CTRL) && wb_req.dat[0];
      if (access && wb_req.we && ovr_hit) begin
        overrides[ovr_idx].valid <= wb_req.dat[9];
        overrides[ovr_idx].data  <= wb_req.dat[8:0];
      end
    end
  end

  // read data is captured together with the ack
  always_ff @(posedge clk) begin
    if (access && !wb_req.we) begin
      wb_dat_o <= rd_data;
    end
  end

  ack_follows_cyc: assert property (
    @(posedge clk) disable iff (!arst_n) wb_ack |-> $past(wb_req.cyc)
  ) else $error("wb_ack without a bus cycle");

endmodule

/* source/i2c_write_master.sv */
`include "codec_params.svh"

module i2c_write_master (
  input  logic                 clk,
  input  logic                 arst_n,
  input  codec_pkg::cfg_word_t tx_word,
  input  logic                 tx_start,
  output logic                 tx_done,
  output logic                 tx_nack,
  output logic                 scl,
  output logic                 sda_oe,
  input  logic                 sda_in
);
  import codec_pkg::*;

  localparam int               DIV      = `I2C_CLK_DIV;
  localparam int               DIV_W    = (DIV > 1) ? $clog2(DIV) : 1;
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DIV - 1);

  i2c_state_e       state;
  logic [DIV_W-1:0] div_cnt;
  logic [1:0]       qcnt;      // quarter of the current SCL period
  logic [2:0]       bit_cnt;
  logic [1:0]       byte_cnt;
  logic [23:0]      shreg;
  logic             nack_r;
  logic             tick;
  logic             scl_high;

  assign tick     = (div_cnt == DIV_LAST);
  assign scl_high = (qcnt == 2'd1) || (qcnt == 2'd2);

  always_comb begin
    scl    = 1'b1;
    sda_oe = 1'b0;
    case (state)
      I2C_START: begin
        scl    = (qcnt != 2'd3);
        sda_oe = (qcnt != 2'd0);     // SDA falls with SCL high
      end
      I2C_BIT: begin
        scl    = scl_high;
        sda_oe = !shreg[23];         // MSB first, open drain low for a 0
      end
      I2C_ACK: begin
        scl    = scl_high;
        sda_oe = 1'b0;               // codec drives the acknowledge
      end
      I2C_STOP: begin
        scl    = (qcnt != 2'd0);
        sda_oe = (qcnt < 2'd2);      // SDA rises with SCL high
      end
      default: begin
        scl    = 1'b1;
        sda_oe = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= I2C_IDLE;
      div_cnt  <= '0;
      qcnt     <= '0;
      bit_cnt  <= '0;
      byte_cnt <= '0;
      nack_r   <= 1'b0;
      tx_done  <= 1'b0;
      tx_nack  <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (state == I2C_IDLE) begin
        div_cnt <= '0;
        qcnt    <= '0;
        if (tx_start) begin
          bit_cnt  <= '0;
          byte_cnt <= '0;
          nack_r   <= 1'b0;
          state    <= I2C_START;
        end
      end else begin
        div_cnt <= tick ? '0 : div_cnt + 1'b1;
        if (tick) begin
          qcnt <= qcnt + 1'b1;
        end
        if (tick && (qcnt == 2'd1) && (state == I2C_ACK)) begin
          nack_r <= sda_in;          // high means no acknowledge
        end
        if (tick && (qcnt == 2'd3)) begin
          case (state)
            I2C_START: state <= I2C_BIT;
            I2C_BIT: begin
              bit_cnt <= bit_cnt + 1'b1;   // wraps to 0 after the eighth bit
              if (bit_cnt == 3'd7) begin
                state <= I2C_ACK;
              end
            end
            I2C_ACK: begin
              if (nack_r || (byte_cnt == 2'd2)) begin
                state <= I2C_STOP;
              end else begin
                byte_cnt <= byte_cnt + 1'b1;
                state    <= I2C_BIT;
              end
            end
            I2C_STOP: begin
              tx_done <= 1'b1;
              tx_nack <= nack_r;
              state   <= I2C_IDLE;
            end
            default: state <= I2C_IDLE;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if ((state == I2C_IDLE) && tx_start) begin
      shreg <= tx_word;
    end else if ((state == I2C_BIT) && tick && (qcnt == 2'd3)) begin
      shreg <= {shreg[22:0], 1'b0};
    end
  end

  // data bits and acknowledge only move while SCL is low
  sda_stable_scl_high: assert property (
    @(posedge clk) disable iff (!arst_n)
    ((state inside {I2C_BIT, I2C_ACK}) && scl && $past(scl)) |-> $stable(sda_oe)
  ) else $error("SDA changed while SCL high");

endmodule

/* tb/tb_codec_config.sv */
`include "codec_params.svh"

module tb_codec_config;
  import codec_pkg::*;

  localparam int         CLK_PERIOD    = 8;
  localparam int         WORD_CYCLES   = 30 * 4 * `I2C_CLK_DIV;   // 30 bit times per word
  localparam int         SEQ_CYCLES    = `CODEC_NUM_REGS * WORD_CYCLES;
  localparam int         WATCHDOG_TIME = (6 * SEQ_CYCLES + 8) * CLK_PERIOD;
  localparam int         ACK_LIMIT     = 16;
  localparam int         NACK_WORD     = 3;
  localparam int         RESTART_WORD  = 3;
  localparam logic [7:0] DEV_ADDR      = 8'h34;
  localparam logic [4:0] ADDR_CTRL     = 5'h00;
  localparam logic [4:0] ADDR_STATUS   = 5'h01;
  localparam logic [4:0] ADDR_OVR      = 5'h10;

  logic        clk = 1'b0;
  logic        arst_n;
  wb_req_t     wb_req;
  logic [15:0] wb_dat_o;
  logic        wb_ack;
  logic        scl;
  logic        sda_oe;
  logic        sda_in;
  int          nack_at;
  logic        start_seen;
  logic        word_valid;
  logic [23:0] word;
  int          byte_total;

  override_t   ovr_mirror [`CODEC_NUM_REGS];   // what the host has written
  int          word_count = 0;
  int          start_count = 0;
  int          run_base;
  int          start_base;
  logic [31:0] rng;
  logic [15:0] rd;

  always #(CLK_PERIOD / 2) clk = ~clk;

  codec_config_top UUT (
    .clk      (clk),
    .arst_n   (arst_n),
    .wb_req   (wb_req),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack),
    .scl      (scl),
    .sda_oe   (sda_oe),
    .sda_in   (sda_in)
  );

  tb_i2c_codec_model codec (
    .clk        (clk),
    .arst_n     (arst_n),
    .scl        (scl),
    .sda_oe     (sda_oe),
    .nack_at    (nack_at),
    .sda_in     (sda_in),
    .start_seen (start_seen),
    .word_valid (word_valid),
    .word       (word),
    .byte_total (byte_total)
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // WM8731 power-up words with any valid host override applied
  function automatic logic [23:0] expected_word(input logic [3:0] index, input override_t ovr);
    cfg_word_t w;
    w.dev_addr = DEV_ADDR;
    w.reg_addr = {3'b000, index};
    case (index)
      4'd0, 4'd1: w.reg_data = 9'h01A;   // line in volume
      4'd2, 4'd3: w.reg_data = 9'h072;   // headphone volume
      4'd4:       w.reg_data = 9'h07C;
      4'd5:       w.reg_data = 9'h006;
      4'd6:       w.reg_data = 9'h000;
      4'd7:       w.reg_data = 9'h001;
      4'd8:       w.reg_data = 9'h002;
      4'd9:       w.reg_data = 9'h001;
      default:    w.reg_data = 9'h000;
    endcase
    if (ovr.valid) begin
      w.reg_data = ovr.data;
    end
    return w;
  endfunction

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, expected);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic wait_ack();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > ACK_LIMIT) abort_run("Wishbone access got no ack");
    end while (!wb_ack);
  endtask

  task automatic wb_write(input logic [4:0] adr, input logic [15:0] dat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    wait_ack();
    wb_req <= '0;
  endtask

  task automatic wb_read(input logic [4:0] adr, output logic [15:0] dat);
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 16'h0000};
    wait_ack();
    dat = wb_dat_o;
    wb_req <= '0;
  endtask

  task automatic begin_run();
    run_base   = word_count;
    start_base = start_count;
    wb_write(ADDR_CTRL, 16'h0001);
  endtask

  // block until the current run has delivered n words
  task automatic wait_words(input int n);
    int waited;
    waited = 0;
    while (word_count - run_base < n) begin
      @(posedge clk);
      waited++;
      if (waited > WORD_CYCLES * (n + 1)) abort_run("I2C writes stalled during a run");
    end
  endtask

  task automatic finish_run(input int words, input int starts, input logic [2:0] status);
    logic [15:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[1]) begin
      wb_read(ADDR_STATUS, st);
      polls++;
      if (polls > SEQ_CYCLES) abort_run("sequencer never reported done");
    end
    check("status", {29'd0, st[2:0]}, {29'd0, status});
    check("words captured", word_count - run_base, words);
    check("transfers begun", start_count - start_base, starts);
  endtask

  // every captured write is compared with the reference as it arrives
  always @(posedge clk) begin
    int          idx;
    logic [23:0] exp_w;
    if (start_seen) start_count <= start_count + 1;
    if (word_valid) begin
      idx = word_count - run_base;
      if (idx >= `CODEC_NUM_REGS) abort_run("more I2C writes than codec registers");
      exp_w = expected_word(4'(idx), ovr_mirror[idx]);
      check("i2c word", {8'h00, word}, {8'h00, exp_w});
      word_count <= word_count + 1;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    abort_run("run timed out before all tests finished");
  end

  initial begin
    arst_n  = 1'b0;
    wb_req  = '0;
    nack_at = -1;
    rng     = 32'd95629;
    for (int i = 0; i < `CODEC_NUM_REGS; i++) ovr_mirror[i] = '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    // defaults only
    wb_read(ADDR_STATUS, rd);
    check("status after reset", {16'h0, rd}, 32'h0);
    begin_run();
    finish_run(10, 10, 3'b010);

    // random overrides on a few registers and their readback
    for (int i = 0; i < `CODEC_NUM_REGS; i++) begin
      if (i inside {1, 4, 5, 7, 9}) begin
        rng = next_random(rng);
        ovr_mirror[i] = '{valid: 1'b1, data: rng[8:0]};
        wb_write(ADDR_OVR + 5'(i), {6'b0, 1'b1, rng[8:0]});
      end
    end
    for (int i = 0; i < `CODEC_NUM_REGS; i++) begin
      wb_read(ADDR_OVR + 5'(i), rd);
      check("override readback", {16'h0, rd}, {22'd0, ovr_mirror[i].valid, ovr_mirror[i].data});
    end
    begin_run();
    finish_run(10, 10, 3'b010);

    // register 4 falls back to its default once its override is dropped
    ovr_mirror[4].valid = 1'b0;
    wb_write(ADDR_OVR + 5'd4, {6'b0, 1'b0, ovr_mirror[4].data});
    begin_run();
    finish_run(10, 10, 3'b010);

    // codec refuses the register byte of one word
    @(posedge clk);
    nack_at <= byte_total + 3 * NACK_WORD + 1;
    begin_run();
    finish_run(NACK_WORD, NACK_WORD + 1, 3'b110);
    @(posedge clk);
    nack_at <= -1;
    begin_run();
    finish_run(10, 10, 3'b010);

    // second start well into a run, after a few words are out
    begin_run();
    wait_words(RESTART_WORD);
    wb_read(ADDR_STATUS, rd);
    check("status busy", {31'd0, rd[0]}, 32'd1);
    wb_write(ADDR_CTRL, 16'h0001);
    finish_run(10, 10, 3'b010);

    $display("Simulation passed");
    $finish;
  end

endmodule

/* tb/tb_i2c_codec_model.sv */
module tb_i2c_codec_model (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        scl,
  input  logic        sda_oe,
  input  int          nack_at,     // byte number whose acknowledge is withheld, -1 for none
  output logic        sda_in,
  output logic        start_seen,
  output logic        word_valid,
  output logic [23:0] word,
  output int          byte_total
);

  logic        pull;
  logic        sda;
  logic        scl_q;
  logic        sda_q;
  logic        active;
  logic        ack_phase;
  logic [3:0]  bit_cnt;
  logic [1:0]  byte_cnt;
  logic [23:0] shreg;

  // wired-AND bus with a pull-up
  assign sda    = !(sda_oe || pull);
  assign sda_in = sda;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
      pull       <= 1'b0;
      active     <= 1'b0;
      ack_phase  <= 1'b0;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      shreg      <= '0;
      word       <= '0;
      word_valid <= 1'b0;
      start_seen <= 1'b0;
      byte_total <= 0;
    end else begin
      scl_q      <= scl;
      sda_q      <= sda;
      start_seen <= 1'b0;
      word_valid <= 1'b0;
      if (scl_q && scl && sda_q && !sda) begin   // start condition
        active     <= 1'b1;
        ack_phase  <= 1'b0;
        pull       <= 1'b0;
        bit_cnt    <= '0;
        byte_cnt   <= '0;
        start_seen <= 1'b1;
      end else if (scl_q && scl && !sda_q && sda) begin   // stop condition
        active <= 1'b0;
        pull   <= 1'b0;
      end else if (active && !scl_q && scl) begin
        if (bit_cnt < 4'd8) begin
          shreg   <= {shreg[22:0], sda};
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if (active && scl_q && !scl) begin
        if (ack_phase) begin
          // ninth clock over, hand SDA back to the master
          pull      <= 1'b0;
          ack_phase <= 1'b0;
          bit_cnt   <= '0;
          byte_cnt  <= byte_cnt + 2'd1;
          if (byte_cnt == 2'd2) begin
            word       <= shreg;
            word_valid <= 1'b1;
          end
        end else if (bit_cnt == 4'd8) begin
          ack_phase  <= 1'b1;
          pull       <= (byte_total != nack_at);
          byte_total <= byte_total + 1;
        end
      end
    end
  end

endmodule
